// File: src/img_geom_pkg.sv
`default_nettype none

package img_geom_pkg;

	localparam int IMG_SIDE     = 8;   // pixels per row and per column
	localparam int MAX_CHANNELS = 32;
	localparam int MIN_CHANNELS = 8;
	localparam int COORD_W      = 3;   // row / column index
	localparam int CHAN_W       = 5;   // channel index
	localparam int ADDR_W       = 11;
	localparam int PIX_W        = 8;

	// ram address, flat during load, split fields during scans
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [CHAN_W-1:0]  ch;
			logic [COORD_W-1:0] row;
			logic [COORD_W-1:0] col;
		} f;
	} pix_addr_u;

endpackage

`default_nettype wire

// File: src/img_op_pkg.sv
`default_nettype none

package img_op_pkg;

	localparam int OP_W = 4;

	// command opcodes
	localparam logic [OP_W-1:0] OP_LOAD        = 4'd0;
	localparam logic [OP_W-1:0] OP_RIGHT       = 4'd1;
	localparam logic [OP_W-1:0] OP_LEFT        = 4'd2;
	localparam logic [OP_W-1:0] OP_UP          = 4'd3;
	localparam logic [OP_W-1:0] OP_DOWN        = 4'd4;
	localparam logic [OP_W-1:0] OP_CH_REDUCE   = 4'd5;
	localparam logic [OP_W-1:0] OP_CH_INCREASE = 4'd6;
	localparam logic [OP_W-1:0] OP_DISPLAY     = 4'd7;
	localparam logic [OP_W-1:0] OP_CONV        = 4'd8;

	localparam int OUT_W        = 14;
	localparam int DRAIN_CYCLES = 3;   // last read to ready pulse

endpackage

`default_nettype wire

// File: src/op_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module op_ctrl (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_op_valid,
	input  logic [img_op_pkg::OP_W-1:0] i_op_mode,
	input  logic                        i_scan_done,
	output logic [img_op_pkg::OP_W-1:0] o_op,
	output logic                        o_start,
	output logic                        o_op_ready
);

	localparam int DW = $clog2(img_op_pkg::DRAIN_CYCLES);

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_READY   = 3'd1;
	localparam logic [2:0] S_WAIT    = 3'd2;
	localparam logic [2:0] S_RUNNING = 3'd3;
	localparam logic [2:0] S_DRAIN   = 3'd4;
	localparam logic [2:0] S_FINISH  = 3'd5;

	logic [2:0]    state, state_n;
	logic [DW-1:0] drain_cnt;
	logic          capture;
	logic          long_op;   // op that runs the scanner

	assign capture    = (state == S_WAIT) && i_op_valid;
	assign long_op    = (o_op == img_op_pkg::OP_LOAD) || (o_op == img_op_pkg::OP_DISPLAY)
		|| (o_op == img_op_pkg::OP_CONV);
	assign o_op_ready = (state == S_READY);

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_n = state;
		case (state)
			S_IDLE:    state_n = S_FINISH;
			S_FINISH:  state_n = S_READY;
			S_READY:   state_n = S_WAIT;
			S_WAIT:    if (i_op_valid) state_n = S_RUNNING;
			S_RUNNING: begin
				if (!long_op)
					state_n = S_FINISH;   // moves and channel steps
				else if (i_scan_done)
					state_n = S_DRAIN;
			end
			S_DRAIN: begin
				if (drain_cnt == DW'(img_op_pkg::DRAIN_CYCLES - 1))
					state_n = S_READY;
			end
			default:   state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= S_IDLE;
			drain_cnt <= '0;
			o_start   <= 1'b0;
			o_op      <= '0;
		end else begin
			state   <= state_n;
			o_start <= capture;
			if (capture)
				o_op <= i_op_mode;   // command register
			if (state == S_DRAIN)
				drain_cnt <= drain_cnt + 1'b1;
			else
				drain_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/window_origin.sv
`timescale 1ns/1ps
`default_nettype none

module window_origin (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_start,
	input  logic [img_op_pkg::OP_W-1:0]      i_op,
	output logic [img_geom_pkg::COORD_W-1:0] o_row,
	output logic [img_geom_pkg::COORD_W-1:0] o_col,
	output logic [img_geom_pkg::CHAN_W:0]    o_channels
);

	localparam int CW = img_geom_pkg::COORD_W;
	localparam int NW = img_geom_pkg::CHAN_W + 1;

	localparam logic [CW-1:0] EDGE   = CW'(img_geom_pkg::IMG_SIDE - 2);   // last origin
	localparam logic [NW-1:0] CH_MAX = NW'(img_geom_pkg::MAX_CHANNELS);
	localparam logic [NW-1:0] CH_MIN = NW'(img_geom_pkg::MIN_CHANNELS);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_row      <= '0;
			o_col      <= '0;
			o_channels <= CH_MAX;
		end else if (i_start) begin
			case (i_op)
				img_op_pkg::OP_RIGHT: if (o_col != EDGE) o_col <= o_col + 1'b1;
				img_op_pkg::OP_LEFT:  if (o_col != '0) o_col <= o_col - 1'b1;
				img_op_pkg::OP_DOWN:  if (o_row != EDGE) o_row <= o_row + 1'b1;
				img_op_pkg::OP_UP:    if (o_row != '0) o_row <= o_row - 1'b1;
				img_op_pkg::OP_CH_INCREASE: begin
					if (o_channels != CH_MAX)
						o_channels <= o_channels << 1;   // double
				end
				img_op_pkg::OP_CH_REDUCE: begin
					if (o_channels != CH_MIN)
						o_channels <= o_channels >> 1;   // halve
				end
				default: ;   // scans and load leave it alone
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/scan_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module scan_addr_gen #(
	parameter int MEM_DEPTH = 2048
) (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_start,
	input  logic [img_op_pkg::OP_W-1:0]      i_op,
	input  logic                             i_in_valid,
	input  logic [img_geom_pkg::COORD_W-1:0] i_row,
	input  logic [img_geom_pkg::COORD_W-1:0] i_col,
	input  logic [img_geom_pkg::CHAN_W:0]    i_channels,
	output img_geom_pkg::pix_addr_u          o_addr,
	output logic                             o_wen,
	output logic                             o_rd,
	output logic                             o_tap_in,
	output logic [3:0]                       o_tap_idx,
	output logic                             o_first_tap,
	output logic                             o_last_tap,
	output logic                             o_done
);

	localparam int AW = img_geom_pkg::ADDR_W;
	localparam int CW = img_geom_pkg::COORD_W;
	localparam int HW = img_geom_pkg::CHAN_W;

	logic          load_busy;
	logic [AW-1:0] load_cnt;
	logic          loading, load_take, load_last;
	logic          scan_busy, scan_conv, scan_last;
	logic [1:0]    pos;    // window pixel or window position
	logic [HW-1:0] ch;
	logic [3:0]    tap;
	logic [HW:0]   ch_last_w;
	logic          ch_end;
	logic [CW-1:0] base_row, base_col;
	logic [1:0]    tap_row, tap_col;
	logic [CW:0]   tr, tc;   // msb set means outside the image

	assign loading   = load_busy || (i_start && (i_op == img_op_pkg::OP_LOAD));
	assign load_take = loading && i_in_valid;
	assign load_last = load_take && (load_cnt == AW'(MEM_DEPTH - 1));
	assign ch_last_w = i_channels - 1'b1;
	assign ch_end    = (ch == ch_last_w[HW-1:0]);
	assign scan_last = (pos == 2'd3) && ch_end && (!scan_conv || (tap == 4'd8));

	// ----------------------------------------
	// counters
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			load_busy <= 1'b0;
			load_cnt  <= '0;
			scan_busy <= 1'b0;
			scan_conv <= 1'b0;
			pos       <= '0;
			ch        <= '0;
			tap       <= '0;
		end else begin
			if (load_last) begin
				load_busy <= 1'b0;
				load_cnt  <= '0;
			end else begin
				load_busy <= loading;
				if (load_take)
					load_cnt <= load_cnt + 1'b1;
			end

			if (i_start && (i_op == img_op_pkg::OP_DISPLAY || i_op == img_op_pkg::OP_CONV)) begin
				scan_busy <= 1'b1;
				scan_conv <= (i_op == img_op_pkg::OP_CONV);
				pos       <= '0;
				ch        <= '0;
				tap       <= '0;
			end else if (scan_busy) begin
				if (scan_last)
					scan_busy <= 1'b0;
				if (scan_conv) begin   // tap, then channel, then position
					if (tap == 4'd8) begin
						tap <= '0;
						ch  <= ch_end ? '0 : ch + 1'b1;
						if (ch_end)
							pos <= pos + 1'b1;
					end else begin
						tap <= tap + 1'b1;
					end
				end else begin   // pixel, then channel
					pos <= pos + 1'b1;
					if (pos == 2'd3)
						ch <= ch_end ? '0 : ch + 1'b1;
				end
			end
		end
	end

	// ----------------------------------------
	// address and tap flags
	// ----------------------------------------
	always_comb begin
		base_row = i_row + CW'(pos[1]);
		base_col = i_col + CW'(pos[0]);
		tap_row  = (tap >= 4'd6) ? 2'd2 : ((tap >= 4'd3) ? 2'd1 : 2'd0);
		case (tap)
			4'd0, 4'd3, 4'd6: tap_col = 2'd0;
			4'd1, 4'd4, 4'd7: tap_col = 2'd1;
			default:          tap_col = 2'd2;
		endcase
		tr = {1'b0, base_row};
		tc = {1'b0, base_col};
		if (scan_conv) begin   // tap offset -1..+1 around the center
			tr = tr + {2'b00, tap_row} - 1'b1;
			tc = tc + {2'b00, tap_col} - 1'b1;
		end
		o_addr = '0;
		if (loading) begin
			o_addr.flat = load_cnt;
		end else begin
			o_addr.f.ch  = ch;
			o_addr.f.row = tr[CW-1:0];
			o_addr.f.col = tc[CW-1:0];
		end
	end

	assign o_wen       = load_take;
	assign o_rd        = scan_busy;
	assign o_tap_in    = !scan_conv || (!tr[CW] && !tc[CW]);
	assign o_tap_idx   = tap;
	assign o_first_tap = scan_busy && scan_conv && (tap == 4'd0) && (ch == '0);
	assign o_last_tap  = scan_busy && scan_conv && (tap == 4'd8) && ch_end;
	assign o_done      = load_last || (scan_busy && scan_last);

endmodule

`default_nettype wire

// File: src/pixel_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_ram #(
	parameter int MEM_DEPTH = 2048
) (
	input  logic                           i_clk,
	input  img_geom_pkg::pix_addr_u        i_addr,
	input  logic                           i_wen,
	input  logic [img_geom_pkg::PIX_W-1:0] i_wdata,
	output logic [img_geom_pkg::PIX_W-1:0] o_rdata
);

	logic [img_geom_pkg::PIX_W-1:0] mem [MEM_DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_wen)
			mem[i_addr.flat] <= i_wdata;
		o_rdata <= mem[i_addr.flat];   // one cycle read
	end

endmodule

`default_nettype wire

// File: src/result_path.sv
`timescale 1ns/1ps
`default_nettype none

module result_path (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic [img_op_pkg::OP_W-1:0]    i_op,
	input  logic                           i_rd,
	input  logic                           i_tap_in,
	input  logic [3:0]                     i_tap_idx,
	input  logic                           i_first_tap,
	input  logic                           i_last_tap,
	input  logic [img_geom_pkg::PIX_W-1:0] i_rdata,
	output logic                           o_out_valid,
	output logic [img_op_pkg::OUT_W-1:0]   o_out_data
);

	localparam int ACC_W = 17;   // 16 x 255 x 32 fits
	localparam int OW    = img_op_pkg::OUT_W;

	logic             rd_d, tap_in_d, first_d, last_d;
	logic [3:0]       idx_d;
	logic [ACC_W-1:0] acc, term, sum, rounded;
	logic             is_disp, is_conv;

	assign is_disp = (i_op == img_op_pkg::OP_DISPLAY);
	assign is_conv = (i_op == img_op_pkg::OP_CONV);

	// flags line up with ram read data
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_d        <= 1'b0;
			tap_in_d    <= 1'b0;
			first_d     <= 1'b0;
			last_d      <= 1'b0;
			idx_d       <= '0;
			o_out_valid <= 1'b0;
		end else begin
			rd_d        <= i_rd;
			tap_in_d    <= i_tap_in;
			first_d     <= i_first_tap;
			last_d      <= i_last_tap;
			idx_d       <= i_tap_idx;
			o_out_valid <= (rd_d && is_disp) || last_d;
		end
	end

	// 1 2 1 / 2 4 2 / 1 2 1 kernel
	always_comb begin
		case (idx_d)
			4'd4:                   term = ACC_W'(i_rdata) << 2;
			4'd1, 4'd3, 4'd5, 4'd7: term = ACC_W'(i_rdata) << 1;
			default:                term = ACC_W'(i_rdata);
		endcase
		if (!tap_in_d)
			term = '0;   // zero padding
		sum     = (first_d ? '0 : acc) + term;
		rounded = sum + ACC_W'(8);
	end

	always_ff @(posedge i_clk) begin
		if (rd_d && is_conv)
			acc <= sum;
		if (rd_d && is_disp)
			o_out_data <= OW'(i_rdata);
		else if (last_d)
			o_out_data <= OW'(rounded >> 4);   // divide by 16, half up
	end

endmodule

`default_nettype wire

// File: src/img_core.sv
`timescale 1ns/1ps
`default_nettype none

module img_core #(
	parameter int MEM_DEPTH = img_geom_pkg::MAX_CHANNELS * img_geom_pkg::IMG_SIDE
		* img_geom_pkg::IMG_SIDE
) (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_op_valid,
	input  logic [img_op_pkg::OP_W-1:0]    i_op_mode,
	output logic                           o_op_ready,
	input  logic                           i_in_valid,
	input  logic [img_geom_pkg::PIX_W-1:0] i_in_data,
	output logic                           o_out_valid,
	output logic [img_op_pkg::OUT_W-1:0]   o_out_data
);

	logic [img_op_pkg::OP_W-1:0]      cur_op;
	logic                             start;
	logic                             scan_done;
	logic [img_geom_pkg::COORD_W-1:0] org_row;
	logic [img_geom_pkg::COORD_W-1:0] org_col;
	logic [img_geom_pkg::CHAN_W:0]    channels;
	img_geom_pkg::pix_addr_u          ram_addr;
	logic                             ram_wen;
	logic [img_geom_pkg::PIX_W-1:0]   ram_rdata;
	logic                             rd;
	logic                             tap_in;
	logic [3:0]                       tap_idx;
	logic                             first_tap;
	logic                             last_tap;

	op_ctrl u_op_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_scan_done (scan_done),
		.o_op        (cur_op),
		.o_start     (start),
		.o_op_ready  (o_op_ready)
	);

	window_origin u_window_origin (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (start),
		.i_op       (cur_op),
		.o_row      (org_row),
		.o_col      (org_col),
		.o_channels (channels)
	);

	scan_addr_gen #(.MEM_DEPTH(MEM_DEPTH)) u_scan_addr_gen (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (start),
		.i_op        (cur_op),
		.i_in_valid  (i_in_valid),
		.i_row       (org_row),
		.i_col       (org_col),
		.i_channels  (channels),
		.o_addr      (ram_addr),
		.o_wen       (ram_wen),
		.o_rd        (rd),
		.o_tap_in    (tap_in),
		.o_tap_idx   (tap_idx),
		.o_first_tap (first_tap),
		.o_last_tap  (last_tap),
		.o_done      (scan_done)
	);

	pixel_ram #(.MEM_DEPTH(MEM_DEPTH)) u_pixel_ram (
		.i_clk   (i_clk),
		.i_addr  (ram_addr),
		.i_wen   (ram_wen),
		.i_wdata (i_in_data),
		.o_rdata (ram_rdata)
	);

	result_path u_result_path (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op        (cur_op),
		.i_rd        (rd),
		.i_tap_in    (tap_in),
		.i_tap_idx   (tap_idx),
		.i_first_tap (first_tap),
		.i_last_tap  (last_tap),
		.i_rdata     (ram_rdata),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

`default_nettype wire

// File: verif/img_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module img_core_properties (
	input logic                           i_clk,
	input logic                           i_rst_n,
	input logic                           i_op_ready,
	input logic                           i_out_valid,
	input logic [img_op_pkg::OUT_W-1:0]   i_out_data,
	input logic [img_op_pkg::OP_W-1:0]    i_op
);

	int fail_cnt = 0;

	// ready is a single-cycle pulse
	ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_op_ready |=> !i_op_ready)
		else begin
			$error("o_op_ready stayed high for two cycles");
			fail_cnt++;
		end

	ready_vs_out: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_op_ready && i_out_valid))
		else begin
			$error("o_op_ready and o_out_valid high in the same cycle");
			fail_cnt++;
		end

	// no output words while the image is loading
	quiet_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_op == img_op_pkg::OP_LOAD) |-> !i_out_valid)
		else begin
			$error("o_out_valid high during a load");
			fail_cnt++;
		end

	display_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_out_valid && i_op == img_op_pkg::OP_DISPLAY) |-> (i_out_data[13:8] == '0))
		else begin
			$error("display word has upper bits set");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// File: verif/img_checker.sv
`timescale 1ns/1ps
`default_nettype none

module img_checker (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_op_valid,
	input  logic [img_op_pkg::OP_W-1:0]    i_op_mode,
	input  logic                           i_in_valid,
	input  logic [img_geom_pkg::PIX_W-1:0] i_in_data,
	input  logic                           i_op_ready,
	input  logic                           i_out_valid,
	input  logic [img_op_pkg::OUT_W-1:0]   i_out_data,
	input  int                             i_exp_words,
	output int                             o_value_errs,
	output int                             o_other_errs
);

	localparam int SIDE   = img_geom_pkg::IMG_SIDE;
	localparam int PIXELS = img_geom_pkg::MAX_CHANNELS * SIDE * SIDE;

	logic [img_geom_pkg::PIX_W-1:0] shadow [PIXELS];   // image as loaded
	logic [img_op_pkg::OP_W-1:0]    cur_op = '0;
	int exp_q [$];
	int org_row = 0;
	int org_col = 0;
	int channels = img_geom_pkg::MAX_CHANNELS;
	int load_idx = 0;
	int words = 0;
	int cyc = 0;
	int last_byte_cyc = 0;
	int value_errs = 0;
	int other_errs = 0;
	bit loading = 1'b0;
	bit busy = 1'b0;
	bit booted = 1'b0;   // first ready after reset has no command

	assign o_value_errs = value_errs;
	assign o_other_errs = other_errs;

	function automatic int pixel(int ch, int row, int col);
		img_geom_pkg::pix_addr_u a;
		if (row < 0 || row >= SIDE || col < 0 || col >= SIDE)
			return 0;   // zero padding
		a.f.ch  = img_geom_pkg::CHAN_W'(ch);
		a.f.row = img_geom_pkg::COORD_W'(row);
		a.f.col = img_geom_pkg::COORD_W'(col);
		return int'(shadow[a.flat]);
	endfunction

	// ----------------------------------------
	// expected words
	// ----------------------------------------
	task automatic queue_display();
		for (int ch = 0; ch < channels; ch++)
			for (int p = 0; p < 4; p++)   // tl, tr, bl, br
				exp_q.push_back(pixel(ch, org_row + p / 2, org_col + p % 2));
	endtask

	task automatic queue_conv();
		int sum;
		int wr;
		int wc;
		for (int p = 0; p < 4; p++) begin
			sum = 0;
			for (int ch = 0; ch < channels; ch++)
				for (int dr = -1; dr <= 1; dr++)
					for (int dc = -1; dc <= 1; dc++) begin
						wr = (dr == 0) ? 2 : 1;
						wc = (dc == 0) ? 2 : 1;
						sum += wr * wc * pixel(ch, org_row + p / 2 + dr, org_col + p % 2 + dc);
					end
			exp_q.push_back((sum + 8) / 16);   // round half up
		end
	endtask

	task automatic start_command(input logic [img_op_pkg::OP_W-1:0] op);
		busy   = 1'b1;
		cur_op = op;
		words  = 0;
		exp_q.delete();
		case (op)
			img_op_pkg::OP_LOAD: begin
				loading  = 1'b1;
				load_idx = 0;
			end
			img_op_pkg::OP_RIGHT:       if (org_col < SIDE - 2) org_col++;
			img_op_pkg::OP_LEFT:        if (org_col > 0) org_col--;
			img_op_pkg::OP_DOWN:        if (org_row < SIDE - 2) org_row++;
			img_op_pkg::OP_UP:          if (org_row > 0) org_row--;
			img_op_pkg::OP_CH_REDUCE:   if (channels > img_geom_pkg::MIN_CHANNELS) channels /= 2;
			img_op_pkg::OP_CH_INCREASE: if (channels < img_geom_pkg::MAX_CHANNELS) channels *= 2;
			img_op_pkg::OP_DISPLAY:     queue_display();
			img_op_pkg::OP_CONV:        queue_conv();
			default: begin
				other_errs++;
				$display("Error at time %0t: unknown opcode %0d issued", $time, op);
			end
		endcase
	endtask

	task automatic check_word();
		int exp;
		words++;
		if (!busy) begin
			other_errs++;
			$display("Error at time %0t: output word with no command running", $time);
		end else if (exp_q.size() == 0) begin
			other_errs++;
			$display("Error at time %0t: more output words than expected", $time);
		end else begin
			exp = exp_q.pop_front();
			if (int'(i_out_data) != exp) begin
				value_errs++;
				$display("Error at time %0t: o_out_data = %0d, expected %0d",
					$time, i_out_data, exp);
			end
		end
	endtask

	task automatic end_command();
		if (!busy) begin
			if (booted) begin
				other_errs++;
				$display("Error at time %0t: ready pulse with no command running", $time);
			end
		end else begin
			if (words != i_exp_words || exp_q.size() != 0) begin
				other_errs++;
				$display("Error at time %0t: opcode %0d gave %0d words, expected %0d",
					$time, cur_op, words, i_exp_words);
			end
			if (loading) begin
				other_errs++;
				$display("Error at time %0t: ready pulse before the load finished", $time);
			end else if (cur_op == img_op_pkg::OP_LOAD
				&& cyc - last_byte_cyc > img_op_pkg::DRAIN_CYCLES + 1) begin
				other_errs++;
				$display("Error at time %0t: ready pulse too late after the last byte", $time);
			end
		end
		busy   = 1'b0;
		booted = 1'b1;
	endtask

	always @(posedge i_clk) begin
		if (i_rst_n) begin
			if (i_out_valid)
				check_word();
			if (i_op_ready)
				end_command();
			if (loading && i_in_valid) begin   // byte taken by the DUT
				shadow[load_idx] = i_in_data;
				load_idx++;
				last_byte_cyc = cyc;
				if (load_idx == PIXELS)
					loading = 1'b0;
			end
			if (i_op_valid)
				start_command(i_op_mode);
			cyc++;
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_img_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_img_core;

	localparam int MAX_LINES  = 32;
	localparam int LOAD_BYTES = 2048;

	logic                           clk = 1'b0;
	logic                           rst_n;
	logic                           op_valid;
	logic [img_op_pkg::OP_W-1:0]    op_mode;
	logic                           op_ready;
	logic                           in_valid;
	logic [img_geom_pkg::PIX_W-1:0] in_data;
	logic                           out_valid;
	logic [img_op_pkg::OUT_W-1:0]   out_data;
	int                             exp_words;
	int                             value_errs;
	int                             other_errs;
	int                             assert_errs;

	logic [15:0] pat [MAX_LINES*3];   // opcode, repeat, words per line
	integer      seed = 47;
	int          n_lines;
	int          cycle_limit;
	int          cycle_cnt = 0;

	always #2 clk = ~clk;

	img_core i_img_core (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_op_valid  (op_valid),
		.i_op_mode   (op_mode),
		.o_op_ready  (op_ready),
		.i_in_valid  (in_valid),
		.i_in_data   (in_data),
		.o_out_valid (out_valid),
		.o_out_data  (out_data)
	);

	img_checker u_checker (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_op_valid   (op_valid),
		.i_op_mode    (op_mode),
		.i_in_valid   (in_valid),
		.i_in_data    (in_data),
		.i_op_ready   (op_ready),
		.i_out_valid  (out_valid),
		.i_out_data   (out_data),
		.i_exp_words  (exp_words),
		.o_value_errs (value_errs),
		.o_other_errs (other_errs)
	);

	bind img_core img_core_properties u_properties (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_ready  (o_op_ready),
		.i_out_valid (o_out_valid),
		.i_out_data  (o_out_data),
		.i_op        (cur_op)
	);

	assign assert_errs = i_img_core.u_properties.fail_cnt;

	function automatic int cmd_budget(logic [15:0] op, logic [15:0] words);
		if (op[3:0] == img_op_pkg::OP_LOAD)
			return 2 * LOAD_BYTES;
		if (op[3:0] == img_op_pkg::OP_DISPLAY)
			return 8 * int'(words);
		if (op[3:0] == img_op_pkg::OP_CONV)
			return 12 * 9 * img_geom_pkg::MAX_CHANNELS * int'(words);
		return 40;   // moves and channel steps
	endfunction

	task automatic wait_ready();
		@(negedge clk);
		while (!op_ready)
			@(negedge clk);
	endtask

	// random bytes, valid dropped about one cycle in eight
	task automatic send_image();
		int   sent;
		logic take;
		sent = 0;
		while (sent < LOAD_BYTES) begin
			take = (($random(seed) & 7) != 0);
			in_valid <= take;
			in_data  <= img_geom_pkg::PIX_W'($random(seed));
			if (take)
				sent++;
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic run_command(input logic [img_op_pkg::OP_W-1:0] op, input int words);
		wait_ready();
		@(posedge clk);
		op_valid  <= 1'b1;
		op_mode   <= op;
		exp_words <= words;
		@(posedge clk);   // capture edge
		op_valid <= 1'b0;
		if (op == img_op_pkg::OP_LOAD)
			send_image();
	endtask

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: no ready pulse after %0d cycles", cycle_cnt);
			$display("errors: %0d value, %0d other, %0d assertion",
				value_errs, other_errs, assert_errs);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		rst_n     = 1'b0;
		op_valid  = 1'b0;
		op_mode   = '0;
		in_valid  = 1'b0;
		in_data   = '0;
		exp_words = 0;
		for (int i = 0; i < MAX_LINES * 3; i++)
			pat[i] = 16'hffff;   // end marker
		$readmemh("verif/img_patterns.txt", pat);
		n_lines     = 0;
		cycle_limit = 50;   // reset and boot
		while (n_lines < MAX_LINES && pat[3*n_lines] != 16'hffff) begin
			cycle_limit += int'(pat[3*n_lines+1]) * cmd_budget(pat[3*n_lines], pat[3*n_lines+2]);
			n_lines++;
		end

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		for (int ln = 0; ln < n_lines; ln++)
			for (int r = 0; r < int'(pat[3*ln+1]); r++)
				run_command(pat[3*ln][img_op_pkg::OP_W-1:0], int'(pat[3*ln+2]));
		wait_ready();
		repeat (4) @(negedge clk);   // let trailing words show up

		$display("errors: %0d value, %0d other, %0d assertion",
			value_errs, other_errs, assert_errs);
		if (value_errs == 0 && other_errs == 0 && assert_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/img_patterns.txt
// columns: opcode, repeat count, output words per command (all hex)
// opcodes: 0 load, 1 right, 2 left, 3 up, 4 down, 5 reduce, 6 increase, 7 display, 8 conv
0 1 000   // load with gaps in i_in_valid
7 1 080   // 32 channels at origin 0,0
8 1 004   // corner, outside taps zero
1 1 000
4 1 000
8 1 004   // interior at 1,1
1 8 000   // saturates at column 6
4 8 000   // saturates at row 6
7 1 080
8 1 004   // bottom right corner
5 3 000   // third reduce has no effect
7 1 020   // 8 channels
6 1 000
7 1 040   // 16 channels
2 1 000
3 1 000
8 1 004

// File: files.f
src/img_geom_pkg.sv
src/img_op_pkg.sv
src/op_ctrl.sv
src/window_origin.sv
src/scan_addr_gen.sv
src/pixel_ram.sv
src/result_path.sv
src/img_core.sv
verif/img_core_properties.sv
verif/img_checker.sv
verif/tb_img_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_img_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
